//--- Makefile
# Verilator build and run for the receive MAC header stage

VERILATOR ?= verilator
TOP       ?= tb_wifi_rx
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

HEADERS   := wifi_rx_consts.svh
SOURCES   := $(shell grep -v '^+' $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source, the header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator exits with a failing status on $fatal
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- addr_filter.sv
// Receiver address match, duplicate detection and last accepted frame memory
`timescale 1ns/1ps
`include "wifi_rx_consts.svh"

module addr_filter (
        input  logic                        clk,
        input  logic                        rstn,
        input  wifi_rx_pkg::mac_hdr_t       hdr,
        input  logic                        hdr_valid,
        input  wifi_rx_pkg::filter_cfg_t    cfg,
        output wifi_rx_pkg::rx_verdict_t    verdict,
        output wifi_rx_pkg::last_acc_t      last_acc
);

        logic   rx_match;
        logic   is_dup;
        logic   last_vld;

        // ***********************************************************
        // Match and duplicate rules

        // Group bit is the LSB of the first address byte
        assign rx_match = cfg.promisc ||
                          (hdr.rx_addr == cfg.own_addr) ||
                          (hdr.rx_addr[0] && cfg.group_en);

        // Nothing to compare against until a frame has been accepted
        assign is_dup = last_vld &&
                        hdr.fc_di[`FC_RETRY_BIT] &&
                        (hdr.tx_addr == last_acc.tx_addr) &&
                        (hdr.seq_ctrl == last_acc.seq_ctrl);

        // ***********************************************************
        // Verdict register

        always_ff @(posedge clk) begin
                if (!rstn) begin
                        verdict  <= '0;
                        last_acc <= '0;
                        last_vld <= 1'b0;
                end else begin
                        verdict <= '0;
                        if (hdr_valid) begin
                                if (rx_match && !is_dup) begin
                                        verdict.accept    <= 1'b1;
                                        last_acc.tx_addr  <= hdr.tx_addr;
                                        last_acc.seq_ctrl <= hdr.seq_ctrl;
                                        last_vld          <= 1'b1;
                                end else begin
                                        verdict.drop <= 1'b1;
                                        verdict.dup  <= rx_match;
                                end
                        end
                end
        end

        // A verdict only follows a header and is never both ways
        property p_verdict_onehot;
                @(posedge clk) disable iff (!rstn)
                (verdict.accept || verdict.drop) |->
                        $past(hdr_valid) && !(verdict.accept && verdict.drop);
        endproperty

        a_verdict_onehot: assert property (p_verdict_onehot)
                else $error("verdict without header or with accept and drop");

endmodule

//--- mac_hdr_parse.sv
// MAC header byte collector with in-order index check and header-complete pulse
`timescale 1ns/1ps
`include "wifi_rx_consts.svh"

module mac_hdr_parse (
        input  logic                    clk,
        input  logic                    rstn,
        input  logic                    byte_valid,
        input  wifi_rx_pkg::byte_idx_t  byte_idx,
        input  wifi_rx_pkg::byte_t      byte_data,
        output wifi_rx_pkg::mac_hdr_t   hdr,
        output logic                    hdr_valid
);
        import wifi_rx_pkg::*;

        byte_idx_t      exp_idx;
        byte_idx_t      field_ofs;
        logic [2:0]     lane;
        logic           in_frame;
        logic           take_byte;
        logic           last_byte;

        // ***********************************************************
        // Byte acceptance

        // Index 0 always restarts, anything else must follow the previous byte
        assign take_byte = byte_valid &&
                           ((byte_idx == '0) || (in_frame && (byte_idx == exp_idx)));

        always_ff @(posedge clk) begin
                if (!rstn) begin
                        in_frame  <= 1'b0;
                        exp_idx   <= '0;
                        last_byte <= 1'b0;
                        hdr_valid <= 1'b0;
                end else begin
                        hdr_valid <= last_byte;
                        last_byte <= 1'b0;
                        if (take_byte) begin
                                exp_idx   <= byte_idx + 1'b1;
                                in_frame  <= (byte_idx != `HDR_LEN-1);
                                last_byte <= (byte_idx == `HDR_LEN-1);
                        end else if (byte_valid) begin
                                // Skipped or repeated index
                                in_frame  <= 1'b0;
                        end
                end
        end

        // ***********************************************************
        // Field placement

        always_comb begin
                if (byte_idx >= `OFS_SRC_ADDR)
                        field_ofs = `OFS_SRC_ADDR;
                else if (byte_idx >= `OFS_SEQ_CTRL)
                        field_ofs = `OFS_SEQ_CTRL;
                else if (byte_idx >= `OFS_DST_ADDR)
                        field_ofs = `OFS_DST_ADDR;
                else if (byte_idx >= `OFS_TX_ADDR)
                        field_ofs = `OFS_TX_ADDR;
                else if (byte_idx >= `OFS_RX_ADDR)
                        field_ofs = `OFS_RX_ADDR;
                else
                        field_ofs = '0;
        end

        // Byte position inside the selected field
        assign lane = 3'(byte_idx - field_ofs);

        always_ff @(posedge clk) begin
                if (take_byte) begin
                        case (field_ofs)
                                `OFS_RX_ADDR:  hdr.rx_addr[lane*8 +: 8]  <= byte_data;
                                `OFS_TX_ADDR:  hdr.tx_addr[lane*8 +: 8]  <= byte_data;
                                `OFS_DST_ADDR: hdr.dst_addr[lane*8 +: 8] <= byte_data;
                                `OFS_SEQ_CTRL: hdr.seq_ctrl[lane*8 +: 8] <= byte_data;
                                `OFS_SRC_ADDR: hdr.src_addr[lane*8 +: 8] <= byte_data;
                                default:       hdr.fc_di[lane*8 +: 8]    <= byte_data;
                        endcase
                end
        end

        // ***********************************************************
        // A new header needs a fresh index 0, so pulses never touch

        property p_valid_single;
                @(posedge clk) disable iff (!rstn)
                hdr_valid |=> !hdr_valid;
        endproperty

        a_valid_single: assert property (p_valid_single)
                else $error("hdr_valid high for two cycles");

endmodule

//--- rx_cfg_regs.sv
// Wishbone classic slave with filter config, frame counters and last accepted readback
`timescale 1ns/1ps
`include "wifi_rx_consts.svh"

module rx_cfg_regs (
        input  logic                        clk,
        input  logic                        rstn,
        input  wifi_rx_pkg::wb_req_t        wb_req,
        input  wifi_rx_pkg::rx_verdict_t    verdict,
        input  wifi_rx_pkg::last_acc_t      last_acc,
        output wifi_rx_pkg::wb_rsp_t        wb_rsp,
        output wifi_rx_pkg::filter_cfg_t    cfg
);
        import wifi_rx_pkg::*;

        wb_state_t      state;
        wb_data_t       rdata;
        wb_data_t       acc_cnt;
        wb_data_t       drop_cnt;
        wb_data_t       dup_cnt;
        logic           ack;
        logic           wr_en;

        // ***********************************************************
        // Single-cycle ack

        always_ff @(posedge clk) begin
                if (!rstn) begin
                        state <= WB_IDLE;
                end else begin
                        case (state)
                                WB_IDLE: if (wb_req.cyc && wb_req.stb) state <= WB_ACK;
                                default: state <= WB_IDLE;
                        endcase
                end
        end

        assign ack   = (state == WB_ACK);
        assign wr_en = ack && wb_req.we;

        // ***********************************************************
        // Config registers, written on the ack edge

        always_ff @(posedge clk) begin
                if (!rstn) begin
                        cfg <= '0;
                end else if (wr_en) begin
                        case (wb_req.adr)
                                `REG_CTRL: begin
                                        cfg.promisc  <= wb_req.wdata[0];
                                        cfg.group_en <= wb_req.wdata[1];
                                end
                                `REG_OWN_LO: cfg.own_addr[31:0]  <= wb_req.wdata;
                                `REG_OWN_HI: cfg.own_addr[47:32] <= wb_req.wdata[15:0];
                                default: ;
                        endcase
                end
        end

        // Duplicates also count as drops
        always_ff @(posedge clk) begin
                if (!rstn) begin
                        acc_cnt  <= '0;
                        drop_cnt <= '0;
                        dup_cnt  <= '0;
                end else begin
                        if (verdict.accept) acc_cnt  <= acc_cnt + 1'b1;
                        if (verdict.drop)   drop_cnt <= drop_cnt + 1'b1;
                        if (verdict.dup)    dup_cnt  <= dup_cnt + 1'b1;
                end
        end

        // ***********************************************************
        // Read mux

        always_comb begin
                case (wb_req.adr)
                        `REG_CTRL:          rdata = {30'd0, cfg.group_en, cfg.promisc};
                        `REG_OWN_LO:        rdata = cfg.own_addr[31:0];
                        `REG_OWN_HI:        rdata = {16'd0, cfg.own_addr[47:32]};
                        `REG_ACC_CNT:       rdata = acc_cnt;
                        `REG_DROP_CNT:      rdata = drop_cnt;
                        `REG_DUP_CNT:       rdata = dup_cnt;
                        `REG_LAST_TX_LO:    rdata = last_acc.tx_addr[31:0];
                        default:            rdata = {last_acc.seq_ctrl, last_acc.tx_addr[47:32]};
                endcase
        end

        assign wb_rsp = '{ack: ack, rdata: rdata};

        // Master holds the cycle until ack
        property p_ack_in_cycle;
                @(posedge clk) disable iff (!rstn)
                wb_rsp.ack |-> wb_req.cyc && wb_req.stb;
        endproperty

        a_ack_in_cycle: assert property (p_ack_in_cycle)
                else $error("ack outside an active Wishbone cycle");

endmodule

//--- sources.f
+incdir+.
wifi_rx_pkg.sv
mac_hdr_parse.sv
addr_filter.sv
rx_cfg_regs.sv
wifi_rx_top.sv
tb_wifi_rx.sv

//--- tb_wifi_rx.sv
// Testbench for wifi_rx_top with a frame table, Wishbone register access and checks
`timescale 1ns/1ps
`include "wifi_rx_consts.svh"

module tb_wifi_rx;
        import wifi_rx_pkg::*;

        localparam int NUM_ROWS        = 13;
        localparam int TRUNC_LEN       = 20;
        localparam int WB_TIMEOUT      = 8;
        localparam int VERDICT_TIMEOUT = 12;
        localparam int QUIET_CYCLES    = 16;
        localparam int VERDICT_LATENCY = 2;
        localparam int DRIVE_DLY       = 1;

        localparam mac_addr_t OWN_A   = 48'h6655_4433_2210;
        localparam mac_addr_t OTHER_A = 48'h6655_4433_2220;
        localparam mac_addr_t GRP_A   = 48'h0000_005e_0001;
        localparam mac_addr_t TX_A    = 48'h0a0b_0c0d_0e02;
        localparam mac_addr_t TX_B    = 48'h1a1b_1c1d_1e04;
        localparam mac_addr_t DST_A   = 48'h2a2b_2c2d_2e06;
        localparam mac_addr_t SRC_A   = 48'h3a3b_3c3d_3e08;
        localparam fc_di_t    FC_DATA  = 32'h002c_0008;
        localparam fc_di_t    FC_RETRY = 32'h002c_0808;

        localparam rx_verdict_t V_NONE = '{accept: 1'b0, drop: 1'b0, dup: 1'b0};
        localparam rx_verdict_t V_ACC  = '{accept: 1'b1, drop: 1'b0, dup: 1'b0};
        localparam rx_verdict_t V_DROP = '{accept: 1'b0, drop: 1'b1, dup: 1'b0};
        localparam rx_verdict_t V_DUP  = '{accept: 1'b0, drop: 1'b1, dup: 1'b1};

        typedef struct packed {
                mac_hdr_t       hdr;
                logic           promisc;
                logic           group_en;
                mac_addr_t      own;
                rx_verdict_t    exp;
                logic           trunc;
        } row_t;

        logic           clk = 1'b0;
        logic           rstn;
        logic           byte_valid;
        byte_idx_t      byte_idx;
        byte_t          byte_data;
        wb_req_t        wb_req;
        wb_rsp_t        wb_rsp;
        rx_verdict_t    verdict;
        mac_hdr_t       hdr;
        row_t           rows [NUM_ROWS];
        logic [31:0]    lfsr = 32'h131d_0d0f;

        always #4 clk = ~clk;

        wifi_rx_top dut_i (
                .clk        (clk),
                .rstn       (rstn),
                .byte_valid (byte_valid),
                .byte_idx   (byte_idx),
                .byte_data  (byte_data),
                .wb_req     (wb_req),
                .wb_rsp     (wb_rsp),
                .verdict    (verdict),
                .hdr        (hdr)
        );

        // ***********************************************************
        // Error handling and compare tasks

        task automatic stop_on_error(input string what);
                $display("%s", what);
                $display("SIMULATION FAILED");
                $fatal(1, "stopped at first error");
        endtask

        task automatic check_verdict(input string name, input rx_verdict_t got,
                                     input rx_verdict_t exp);
                if (got !== exp)
                        stop_on_error($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        endtask

        task automatic check_hdr(input string name, input mac_hdr_t got, input mac_hdr_t exp);
                if (got !== exp)
                        stop_on_error($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        endtask

        task automatic check_word(input string name, input wb_data_t got, input wb_data_t exp);
                if (got !== exp)
                        stop_on_error($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        endtask

        // ***********************************************************
        // Stimulus helpers

        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
        endfunction

        // Two LFSR bits give a gap of 0 to 3 cycles
        task automatic draw_gap(output int gap);
                gap = 0;
                for (int k = 0; k < 2; k++) begin
                        gap = (gap << 1) | int'(lfsr[0]);
                        lfsr = lfsr_next(lfsr);
                end
        endtask

        function automatic row_t make_row(input fc_di_t fc, input mac_addr_t rx,
                                          input mac_addr_t tx, input seq_ctrl_t sc,
                                          input logic [1:0] mode, input mac_addr_t own,
                                          input rx_verdict_t exp, input logic trunc);
                row_t r;
                r.hdr = '{fc_di: fc, rx_addr: rx, tx_addr: tx, dst_addr: DST_A,
                          seq_ctrl: sc, src_addr: SRC_A};
                r.promisc  = mode[0];
                r.group_en = mode[1];
                r.own      = own;
                r.exp      = exp;
                r.trunc    = trunc;
                return r;
        endfunction

        // Mode column holds the CTRL register value with group_en in bit 1 and promisc in bit 0
        task automatic fill_table();
                rows[0]  = make_row(FC_DATA, OWN_A, TX_A, 16'h10, 2'b00, OWN_A, V_ACC, 1'b0);
                rows[1]  = make_row(FC_DATA, OTHER_A, TX_B, 16'h20, 2'b00, OWN_A, V_DROP, 1'b0);
                rows[2]  = make_row(FC_DATA, GRP_A, TX_B, 16'h30, 2'b00, OWN_A, V_DROP, 1'b0);
                rows[3]  = make_row(FC_DATA, GRP_A, TX_B, 16'h30, 2'b10, OWN_A, V_ACC, 1'b0);
                rows[4]  = make_row(FC_DATA, OTHER_A, TX_A, 16'h40, 2'b01, OWN_A, V_ACC, 1'b0);
                rows[5]  = make_row(FC_RETRY, OWN_A, TX_A, 16'h40, 2'b00, OWN_A, V_DUP, 1'b0);
                rows[6]  = make_row(FC_DATA, OWN_A, TX_A, 16'h40, 2'b00, OWN_A, V_ACC, 1'b0);
                rows[7]  = make_row(FC_RETRY, OWN_A, TX_A, 16'h50, 2'b00, OWN_A, V_ACC, 1'b0);
                rows[8]  = make_row(FC_DATA, OWN_A, TX_B, 16'h60, 2'b00, OWN_A, V_NONE, 1'b1);
                rows[9]  = make_row(FC_DATA, OWN_A, TX_B, 16'h70, 2'b00, OWN_A, V_ACC, 1'b0);
                rows[10] = make_row(FC_RETRY, OTHER_A, TX_B, 16'h70, 2'b00, OWN_A, V_DROP, 1'b0);
                rows[11] = make_row(FC_RETRY, OTHER_A, TX_B, 16'h70, 2'b01, OWN_A, V_DUP, 1'b0);
                rows[12] = make_row(FC_DATA, OTHER_A, TX_A, 16'h80, 2'b00, OTHER_A, V_ACC, 1'b0);
        endtask

        // Header byte at frame position i with the earliest byte of a field in its low bits
        function automatic byte_t hdr_byte(input mac_hdr_t h, input int i);
                byte_t b;
                if (i >= `OFS_SRC_ADDR)
                        b = h.src_addr[(i - `OFS_SRC_ADDR)*8 +: 8];
                else if (i >= `OFS_SEQ_CTRL)
                        b = h.seq_ctrl[(i - `OFS_SEQ_CTRL)*8 +: 8];
                else if (i >= `OFS_DST_ADDR)
                        b = h.dst_addr[(i - `OFS_DST_ADDR)*8 +: 8];
                else if (i >= `OFS_TX_ADDR)
                        b = h.tx_addr[(i - `OFS_TX_ADDR)*8 +: 8];
                else if (i >= `OFS_RX_ADDR)
                        b = h.rx_addr[(i - `OFS_RX_ADDR)*8 +: 8];
                else
                        b = h.fc_di[i*8 +: 8];
                return b;
        endfunction

        task automatic send_frame(input mac_hdr_t h, input int nbytes);
                int gap;
                for (int i = 0; i < nbytes; i++) begin
                        draw_gap(gap);
                        repeat (gap) begin
                                @(posedge clk);
                                #DRIVE_DLY;
                        end
                        byte_valid = 1'b1;
                        byte_idx   = byte_idx_t'(i);
                        byte_data  = hdr_byte(h, i);
                        @(posedge clk);
                        #DRIVE_DLY;
                        byte_valid = 1'b0;
                end
        endtask

        // ***********************************************************
        // Wishbone master

        task automatic wb_access(input logic we, input wb_adr_t adr, input wb_data_t wdata,
                                 output wb_data_t rdata);
                int waits;
                waits = 0;
                wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, wdata: wdata};
                @(negedge clk);
                while (!wb_rsp.ack) begin
                        waits++;
                        if (waits > WB_TIMEOUT)
                                stop_on_error("Wishbone access got no ack before the timeout");
                        @(negedge clk);
                end
                if (waits != 1)
                        stop_on_error("Wishbone ack did not come one clock after the request");
                rdata = wb_rsp.rdata;
                @(posedge clk);
                #DRIVE_DLY;
                wb_req = '0;
                @(negedge clk);
                if (wb_rsp.ack)
                        stop_on_error("Wishbone ack stayed high for more than one cycle");
                @(posedge clk);
                #DRIVE_DLY;
        endtask

        task automatic write_reg(input wb_adr_t adr, input wb_data_t data);
                wb_data_t rd;
                wb_access(1'b1, adr, data, rd);
        endtask

        task automatic read_check(input string name, input wb_adr_t adr, input wb_data_t exp);
                wb_data_t rd;
                wb_access(1'b0, adr, '0, rd);
                check_word(name, rd, exp);
        endtask

        // ***********************************************************
        // Verdict waits

        task automatic wait_verdict(output int cycles);
                cycles = 0;
                @(negedge clk);
                while (verdict === V_NONE) begin
                        cycles++;
                        if (cycles > VERDICT_TIMEOUT)
                                stop_on_error("no verdict arrived before the timeout");
                        @(negedge clk);
                end
        endtask

        task automatic expect_no_verdict();
                for (int i = 0; i < QUIET_CYCLES; i++) begin
                        @(negedge clk);
                        if (verdict !== V_NONE)
                                stop_on_error("a truncated frame produced a verdict");
                end
                @(posedge clk);
                #DRIVE_DLY;
        endtask

        task automatic run_row(input row_t r);
                int lat;
                write_reg(`REG_CTRL, {30'd0, r.group_en, r.promisc});
                write_reg(`REG_OWN_LO, r.own[31:0]);
                write_reg(`REG_OWN_HI, {16'd0, r.own[47:32]});
                read_check("ctrl", `REG_CTRL, {30'd0, r.group_en, r.promisc});
                if (r.trunc) begin
                        send_frame(r.hdr, TRUNC_LEN);
                        expect_no_verdict();
                end else begin
                        send_frame(r.hdr, `HDR_LEN);
                        wait_verdict(lat);
                        if (lat != VERDICT_LATENCY)
                                stop_on_error($sformatf(
                                        "verdict came %0d cycles after the last byte", lat));
                        check_verdict("verdict", verdict, r.exp);
                        check_hdr("hdr", hdr, r.hdr);
                        @(negedge clk);
                        check_verdict("verdict", verdict, V_NONE);
                        @(posedge clk);
                        #DRIVE_DLY;
                end
        endtask

        // ***********************************************************
        // Main sequence

        initial begin
                int             n_acc;
                int             n_drop;
                int             n_dup;
                last_acc_t      last_exp;
                rstn       = 1'b0;
                byte_valid = 1'b0;
                byte_idx   = '0;
                byte_data  = '0;
                wb_req     = '0;
                fill_table();
                n_acc    = 0;
                n_drop   = 0;
                n_dup    = 0;
                last_exp = '0;
                for (int i = 0; i < NUM_ROWS; i++) begin
                        if (rows[i].exp.accept) begin
                                n_acc++;
                                last_exp = '{tx_addr: rows[i].hdr.tx_addr,
                                             seq_ctrl: rows[i].hdr.seq_ctrl};
                        end
                        if (rows[i].exp.drop)
                                n_drop++;
                        if (rows[i].exp.dup)
                                n_dup++;
                end
                repeat (4) @(posedge clk);
                #DRIVE_DLY;
                rstn = 1'b1;
                @(negedge clk);
                check_verdict("verdict", verdict, V_NONE);
                if (wb_rsp.ack !== 1'b0)
                        stop_on_error("Wishbone ack is active after reset");
                @(posedge clk);
                #DRIVE_DLY;
                read_check("acc_cnt", `REG_ACC_CNT, '0);

                for (int i = 0; i < NUM_ROWS; i++)
                        run_row(rows[i]);

                // Counters ignore writes
                write_reg(`REG_ACC_CNT, 32'hdead_beef);
                read_check("acc_cnt", `REG_ACC_CNT, wb_data_t'(n_acc));
                read_check("drop_cnt", `REG_DROP_CNT, wb_data_t'(n_drop));
                read_check("dup_cnt", `REG_DUP_CNT, wb_data_t'(n_dup));
                read_check("last_tx_lo", `REG_LAST_TX_LO, last_exp.tx_addr[31:0]);
                read_check("last_tx_hi_sc", `REG_LAST_TX_HI_SC,
                           {last_exp.seq_ctrl, last_exp.tx_addr[47:32]});

                $display("SIMULATION PASSED");
                $finish;
        end

endmodule

//--- wifi_rx_consts.svh
// Header length, field offsets, retry bit, Wishbone address width and register map
`ifndef WIFI_RX_CONSTS_SVH
`define WIFI_RX_CONSTS_SVH

// ***********************************************************
`define HDR_LEN            30
`define OFS_RX_ADDR        4
`define OFS_TX_ADDR        10
`define OFS_DST_ADDR       16
`define OFS_SEQ_CTRL       22
`define OFS_SRC_ADDR       24
`define FC_RETRY_BIT       11

// ***********************************************************
`define WB_ADR_W           3
`define REG_CTRL           3'd0
`define REG_OWN_LO         3'd1
`define REG_OWN_HI         3'd2
`define REG_ACC_CNT        3'd3
`define REG_DROP_CNT       3'd4
`define REG_DUP_CNT        3'd5
`define REG_LAST_TX_LO     3'd6
`define REG_LAST_TX_HI_SC  3'd7

`endif

//--- wifi_rx_pkg.sv
// Vector types, header, verdict, config and Wishbone structs, register port FSM states
`include "wifi_rx_consts.svh"

package wifi_rx_pkg;

        typedef logic [7:0]             byte_t;
        typedef logic [15:0]            byte_idx_t;
        typedef logic [47:0]            mac_addr_t;
        typedef logic [31:0]            fc_di_t;
        typedef logic [15:0]            seq_ctrl_t;
        typedef logic [`WB_ADR_W-1:0]   wb_adr_t;
        typedef logic [31:0]            wb_data_t;

        // Every field holds its first received byte in the low bits
        typedef struct packed {
                fc_di_t         fc_di;
                mac_addr_t      rx_addr;
                mac_addr_t      tx_addr;
                mac_addr_t      dst_addr;
                seq_ctrl_t      seq_ctrl;
                mac_addr_t      src_addr;
        } mac_hdr_t;

        typedef struct packed {
                mac_addr_t      own_addr;
                logic           promisc;
                logic           group_en;
        } filter_cfg_t;

        // dup only ever comes with drop
        typedef struct packed {
                logic           accept;
                logic           drop;
                logic           dup;
        } rx_verdict_t;

        typedef struct packed {
                mac_addr_t      tx_addr;
                seq_ctrl_t      seq_ctrl;
        } last_acc_t;

        typedef struct packed {
                logic           cyc;
                logic           stb;
                logic           we;
                wb_adr_t        adr;
                wb_data_t       wdata;
        } wb_req_t;

        typedef struct packed {
                logic           ack;
                wb_data_t       rdata;
        } wb_rsp_t;

        typedef enum logic {WB_IDLE, WB_ACK} wb_state_t;

endpackage

//--- wifi_rx_top.sv
// Receive MAC header stage with parser, address filter and register block
`timescale 1ns/1ps

module wifi_rx_top (
        input  logic                        clk,
        input  logic                        rstn,
        input  logic                        byte_valid,
        input  wifi_rx_pkg::byte_idx_t      byte_idx,
        input  wifi_rx_pkg::byte_t          byte_data,
        input  wifi_rx_pkg::wb_req_t        wb_req,
        output wifi_rx_pkg::wb_rsp_t        wb_rsp,
        output wifi_rx_pkg::rx_verdict_t    verdict,
        output wifi_rx_pkg::mac_hdr_t       hdr
);
        import wifi_rx_pkg::*;

        logic           hdr_valid;
        filter_cfg_t    cfg;
        last_acc_t      last_acc;

        mac_hdr_parse parse_i (
                .clk        (clk),
                .rstn       (rstn),
                .byte_valid (byte_valid),
                .byte_idx   (byte_idx),
                .byte_data  (byte_data),
                .hdr        (hdr),
                .hdr_valid  (hdr_valid)
        );

        addr_filter filter_i (
                .clk        (clk),
                .rstn       (rstn),
                .hdr        (hdr),
                .hdr_valid  (hdr_valid),
                .cfg        (cfg),
                .verdict    (verdict),
                .last_acc   (last_acc)
        );

        rx_cfg_regs regs_i (
                .clk        (clk),
                .rstn       (rstn),
                .wb_req     (wb_req),
                .verdict    (verdict),
                .last_acc   (last_acc),
                .wb_rsp     (wb_rsp),
                .cfg        (cfg)
        );

endmodule
